//--- common/soc_pkg.sv
package soc_pkg;

    // data word shared by every register
    typedef logic [31:0] word_t;

    // one access from the bus master
    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } bus_req_t;

    // read answer, one cycle after the request
    typedef struct packed {
        logic  valid;
        word_t rdata;
    } bus_rsp_t;

    // one-hot target select
    typedef struct packed {
        logic clint;
        logic timer_fast;
        logic timer_slow;
        logic buttons;
    } target_sel_t;

    // address map
    localparam word_t CLINT_BASE  = 32'h0200_0000;
    localparam word_t TIMER_BASE  = 32'h1000_0000;
    localparam word_t BUTTON_BASE = 32'h1000_0100;

    // cycle counters inside the timer range
    localparam word_t TIMER_FAST_ADDR = TIMER_BASE;
    localparam word_t TIMER_SLOW_ADDR = TIMER_BASE + 32'd4;

    // clint register offsets
    localparam logic [15:0] MSIP_OFS        = 16'h0000;
    localparam logic [15:0] MTIMECMP_LO_OFS = 16'h4000;
    localparam logic [15:0] MTIMECMP_HI_OFS = 16'h4004;
    localparam logic [15:0] MTIME_LO_OFS    = 16'hBFF8;
    localparam logic [15:0] MTIME_HI_OFS    = 16'hBFFC;

    // read value for holes in the map
    localparam word_t UNMAPPED_DATA = 32'h0000_0000;

    localparam int NUM_BUTTONS = 8;

endpackage

//--- rtl/reset_sync.sv
`timescale 1ns/10ps

module reset_sync #(
    parameter int RESET_CNT_WIDTH = 4
) (
    input  logic clk,
    input  logic ext_reset,
    output logic rst_n
);

    logic [RESET_CNT_WIDTH-1:0] reset_cnt;

    // counter is cleared at once, released only on clock edges
    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            reset_cnt <= '0;
        end else if (!rst_n) begin
            reset_cnt <= reset_cnt + 1'b1;
        end
    end

    // internal reset ends once the counter saturates
    assign rst_n = &reset_cnt;

endmodule

//--- rtl/periph_bus.sv
`timescale 1ns/10ps

module periph_bus import soc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  bus_req_t    req,
    output target_sel_t wr_sel,
    input  word_t       clint_rdata,
    input  word_t       fast_rdata,
    input  word_t       slow_rdata,
    input  word_t       button_rdata,
    output bus_rsp_t    rsp
);

    target_sel_t hit;
    logic        rd_strobe;
    word_t       rd_word;
    logic        rsp_valid_q;
    word_t       rsp_data_q;

    // address decode
    // the clint owns its whole 64k window, the others are single words
    always_comb begin
        hit            = '0;
        hit.clint      = (req.addr[31:16] == CLINT_BASE[31:16]);
        hit.timer_fast = (req.addr == TIMER_FAST_ADDR);
        hit.timer_slow = (req.addr == TIMER_SLOW_ADDR);
        hit.buttons    = (req.addr == BUTTON_BASE);
    end

    assign wr_sel    = (req.valid && req.write) ? hit : '0;
    assign rd_strobe = req.valid && !req.write;

    // targets answer combinationally for the current address
    always_comb begin
        if (hit.clint) begin
            rd_word = clint_rdata;
        end else if (hit.timer_fast) begin
            rd_word = fast_rdata;
        end else if (hit.timer_slow) begin
            rd_word = slow_rdata;
        end else if (hit.buttons) begin
            rd_word = button_rdata;
        end else begin
            rd_word = UNMAPPED_DATA;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rd_strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_strobe) begin
            rsp_data_q <= rd_word;
        end
    end

    assign rsp.valid = rsp_valid_q;
    assign rsp.rdata = rsp_data_q;

    // an answer never carries unknown data from a target
    assert property (@(posedge clk) disable iff (!rst_n)
        rsp.valid |-> !$isunknown(rsp.rdata));

    // a strobe comes with a known command and address
    assert property (@(posedge clk) disable iff (!rst_n)
        req.valid |-> !$isunknown({req.write, req.addr}));

endmodule

//--- clint/clint.sv
`timescale 1ns/10ps

module clint import soc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr,
    input  logic [15:0] addr,
    input  word_t       wdata,
    output word_t       rdata,
    output logic        msw_irq,
    output logic        mtimer_irq
);

    logic [63:0] mtime_q;
    logic [63:0] mtime_d;
    logic [63:0] mtimecmp_q;
    logic [63:0] mtimecmp_d;
    logic        msip_q;

    // next values, a write to mtime replaces that cycle's increment
    always_comb begin
        mtime_d    = mtime_q + 64'd1;
        mtimecmp_d = mtimecmp_q;
        if (wr) begin
            case (addr)
                MTIME_LO_OFS:    mtime_d    = {mtime_q[63:32], wdata};
                MTIME_HI_OFS:    mtime_d    = {wdata, mtime_q[31:0]};
                MTIMECMP_LO_OFS: mtimecmp_d = {mtimecmp_q[63:32], wdata};
                MTIMECMP_HI_OFS: mtimecmp_d = {wdata, mtimecmp_q[31:0]};
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            msip_q     <= 1'b0;
            mtimer_irq <= 1'b0;
        end else begin
            mtime_q    <= mtime_d;
            mtimecmp_q <= mtimecmp_d;
            // compare on next values so irq tracks a write within one cycle
            mtimer_irq <= (mtime_d >= mtimecmp_d);
            if (wr && addr == MSIP_OFS) begin
                msip_q <= wdata[0];
            end
        end
    end

    assign msw_irq = msip_q;

    // register read mux
    always_comb begin
        case (addr)
            MSIP_OFS:        rdata = {31'b0, msip_q};
            MTIMECMP_LO_OFS: rdata = mtimecmp_q[31:0];
            MTIMECMP_HI_OFS: rdata = mtimecmp_q[63:32];
            MTIME_LO_OFS:    rdata = mtime_q[31:0];
            MTIME_HI_OFS:    rdata = mtime_q[63:32];
            default:         rdata = UNMAPPED_DATA;
        endcase
    end

    // a register write carries a known offset and value
    assert property (@(posedge clk) disable iff (!rst_n)
        wr |-> !$isunknown({addr, wdata}));

endmodule

//--- rtl/cycle_timer.sv
`timescale 1ns/10ps

module cycle_timer import soc_pkg::*; #(
    parameter int DIVISION = 1
) (
    input  logic  clk,
    input  logic  rst_n,
    output word_t count
);

    logic tick;

    generate
        if (DIVISION == 1) begin : g_no_prescale
            assign tick = 1'b1;
        end else begin : g_prescale
            localparam int PRE_W = $clog2(DIVISION);

            logic [PRE_W-1:0] pre_q;

            // wraps after DIVISION clocks
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    pre_q <= '0;
                end else if (tick) begin
                    pre_q <= '0;
                end else begin
                    pre_q <= pre_q + 1'b1;
                end
            end

            assign tick = (pre_q == PRE_W'(DIVISION - 1));
        end
    endgenerate

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (tick) begin
            count <= count + 32'd1;
        end
    end

endmodule

//--- rtl/button_port.sv
`timescale 1ns/10ps

module button_port import soc_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [NUM_BUTTONS-1:0] buttons_n,
    output word_t                  rdata
);

    logic [NUM_BUTTONS-1:0] sync1_q;
    logic [NUM_BUTTONS-1:0] sync2_q;

    // two-flop synchronizer
    // idle level of an active-low button is high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1_q <= '1;
            sync2_q <= '1;
        end else begin
            sync1_q <= buttons_n;
            sync2_q <= sync1_q;
        end
    end

    // pressed buttons read as ones in the low bits
    always_comb begin
        rdata                  = '0;
        rdata[NUM_BUTTONS-1:0] = ~sync2_q;
    end

endmodule

//--- rtl/soc_periph_top.sv
`timescale 1ns/10ps

module soc_periph_top import soc_pkg::*; #(
    parameter int DIV_SLOW = 50
) (
    input  logic                   clk,
    input  logic                   ext_reset,
    input  bus_req_t               req,
    output bus_rsp_t               rsp,
    input  logic [NUM_BUTTONS-1:0] buttons_n,
    output logic                   msw_irq,
    output logic                   mtimer_irq
);

    logic        rst_n;
    target_sel_t wr_sel;
    word_t       clint_rdata;
    word_t       fast_rdata;
    word_t       slow_rdata;
    word_t       button_rdata;

    reset_sync u_reset_sync (
        .clk       (clk),
        .ext_reset (ext_reset),
        .rst_n     (rst_n)
    );

    periph_bus u_periph_bus (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .wr_sel       (wr_sel),
        .clint_rdata  (clint_rdata),
        .fast_rdata   (fast_rdata),
        .slow_rdata   (slow_rdata),
        .button_rdata (button_rdata),
        .rsp          (rsp)
    );

    // clint sees only the offset inside its window
    clint u_clint (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr         (wr_sel.clint),
        .addr       (req.addr[15:0]),
        .wdata      (req.wdata),
        .rdata      (clint_rdata),
        .msw_irq    (msw_irq),
        .mtimer_irq (mtimer_irq)
    );

    cycle_timer #(.DIVISION(1)) u_timer_fast (
        .clk   (clk),
        .rst_n (rst_n),
        .count (fast_rdata)
    );

    cycle_timer #(.DIVISION(DIV_SLOW)) u_timer_slow (
        .clk   (clk),
        .rst_n (rst_n),
        .count (slow_rdata)
    );

    button_port u_button_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .buttons_n (buttons_n),
        .rdata     (button_rdata)
    );

endmodule

//--- verification/tb_soc_periph.sv
`timescale 1ns/10ps

module tb_soc_periph import soc_pkg::*; ();

    localparam int    DIV_SLOW     = 50;
    localparam int    RESET_CYCLES = 2;
    localparam int    RELEASE_WAIT = 16;
    localparam string PATTERN_FILE = "verification/soc_periph_patterns.txt";

    logic                   clk;
    logic                   ext_reset;
    bus_req_t               req;
    bus_rsp_t               rsp;
    logic [NUM_BUTTONS-1:0] buttons_n;
    logic                   msw_irq;
    logic                   mtimer_irq;

    // parsed operations, one entry per pattern line
    string op_q[$];
    word_t addr_q[$];
    string dtok_q[$];
    string etok_q[$];
    int    line_q[$];
    word_t rand_q[$];

    int     mismatch_cnt = 0;
    int     fault_cnt    = 0;
    int     cycle_cnt    = 0;
    int     cycle_limit  = 0;
    integer seed         = 32'hd033_8ed7;

    soc_periph_top #(.DIV_SLOW(DIV_SLOW)) uut (
        .clk        (clk),
        .ext_reset  (ext_reset),
        .req        (req),
        .rsp        (rsp),
        .buttons_n  (buttons_n),
        .msw_irq    (msw_irq),
        .mtimer_irq (mtimer_irq)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // run limit, known once the pattern file is parsed
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic bus_write(input word_t addr, input word_t data);
        bus_req_t r;
        r       = '0;
        r.valid = 1'b1;
        r.write = 1'b1;
        r.addr  = addr;
        r.wdata = data;
        @(posedge clk);
        req <= r;
        @(posedge clk);
        req <= '0;
    endtask

    // answer is due exactly one cycle after the request edge
    task automatic bus_read(input word_t addr, output bus_rsp_t got);
        bus_req_t r;
        r       = '0;
        r.valid = 1'b1;
        r.addr  = addr;
        @(posedge clk);
        req <= r;
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        got = rsp;
    endtask

    task automatic check_rsp(input bus_rsp_t got, input word_t exp, input string what);
        if (!got.valid) begin
            $display("no read response one cycle after the request (%s)", what);
            fault_cnt++;
        end else if (got.rdata !== exp) begin
            $display("mismatch at %0t: %s read %h, expected %h", $time, what, got.rdata, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_range(input bus_rsp_t got, input word_t lo, input word_t hi,
                               input string what);
        if (!got.valid) begin
            $display("no read response one cycle after the request (%s)", what);
            fault_cnt++;
        end else if (got.rdata < lo || got.rdata > hi) begin
            $display("mismatch at %0t: %s read %h, expected %h to %h",
                     $time, what, got.rdata, lo, hi);
            mismatch_cnt++;
        end
    endtask

    task automatic check_irq(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            mismatch_cnt++;
        end
    endtask

    initial begin
        int       fd;
        int       idle_sum;
        int       n;
        string    line;
        string    op;
        string    dtok;
        string    etok;
        string    what;
        word_t    addr;
        word_t    data;
        word_t    exp;
        word_t    last_val;
        bus_rsp_t got;

        ext_reset = 1'b0;
        req       = '0;
        buttons_n = '1;
        idle_sum  = 0;
        last_val  = '0;
        n         = 0;

        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("could not open pattern file %s", PATTERN_FILE);
            fault_cnt++;
        end else begin
            while ($fgets(line, fd)) begin
                n++;
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                if ($sscanf(line, "%s %h %s %s", op, addr, dtok, etok) == 4) begin
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    dtok_q.push_back(dtok);
                    etok_q.push_back(etok);
                    line_q.push_back(n);
                    if (op == "idle") begin
                        void'($sscanf(dtok, "%d", data));
                        idle_sum += data;
                    end
                end else begin
                    $display("pattern line %0d cannot be parsed", n);
                    fault_cnt++;
                end
            end
            $fclose(fd);
        end
        if (op_q.size() == 0) begin
            $display("pattern file holds no operations");
            fault_cnt++;
        end
        cycle_limit = 2 * idle_sum + 4 * op_q.size() + RESET_CYCLES + RELEASE_WAIT;

        repeat (RESET_CYCLES) @(posedge clk);
        ext_reset <= 1'b1;
        // internal reset holds for 15 more cycles
        repeat (RELEASE_WAIT) @(posedge clk);

        foreach (op_q[i]) begin
            op   = op_q[i];
            what = $sformatf("line %0d %s %h", line_q[i], op, addr_q[i]);
            if (op == "wr") begin
                if (dtok_q[i] == "RAND") begin
                    data = $random(seed);
                    rand_q.push_back(data);
                end else begin
                    void'($sscanf(dtok_q[i], "%h", data));
                end
                bus_write(addr_q[i], data);
            end else if (op == "rd") begin
                bus_read(addr_q[i], got);
                if (etok_q[i] == "RAND") begin
                    exp = rand_q.pop_front();
                    check_rsp(got, exp, what);
                end else if (etok_q[i] == "ANY") begin
                    check_range(got, '0, '1, what);
                    last_val = got.rdata;
                end else if (etok_q[i] == "GT") begin
                    check_range(got, last_val + 32'd1, '1, what);
                    last_val = got.rdata;
                end else if (etok_q[i] == "SLOW") begin
                    // slow count against the fast count read just before
                    check_range(got, 32'd1, last_val / DIV_SLOW + 32'd1, what);
                end else begin
                    void'($sscanf(etok_q[i], "%h", exp));
                    check_rsp(got, exp, what);
                end
            end else if (op == "msw" || op == "mtm") begin
                void'($sscanf(etok_q[i], "%h", exp));
                @(negedge clk);
                check_irq((op == "msw") ? msw_irq : mtimer_irq, exp[0], what);
            end else if (op == "idle") begin
                void'($sscanf(dtok_q[i], "%d", data));
                repeat (data) @(posedge clk);
            end else if (op == "btn") begin
                void'($sscanf(dtok_q[i], "%h", data));
                @(posedge clk);
                buttons_n <= data[NUM_BUTTONS-1:0];
            end else begin
                $display("unknown operation %s on pattern line %0d", op, line_q[i]);
                fault_cnt++;
            end
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fault_cnt);
        if (mismatch_cnt == 0 && fault_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verification/soc_periph_patterns.txt
# columns: op addr(hex) data expect, unused fields are -
# wr data is hex or RAND; rd expect is hex, RAND, ANY, GT or SLOW; idle data is decimal
wr 02004000 RAND -
wr 02004004 RAND -
rd 02004000 - RAND
rd 02004004 - RAND
wr 02000000 1 -
msw 0 - 1
rd 02000000 - 00000001
wr 02000000 0 -
msw 0 - 0
rd 02000000 - 00000000
wr 0200bff8 0 -
wr 0200bffc 0 -
wr 02004000 c8 -
wr 02004004 0 -
mtm 0 - 0
idle 0 220 -
mtm 0 - 1
wr 02004000 ffffffff -
wr 02004004 ffffffff -
mtm 0 - 0
rd 0200bff8 - ANY
rd 0200bff8 - GT
idle 0 300 -
rd 10000000 - ANY
rd 10000004 - SLOW
rd 10000000 - GT
btn 0 a5 -
idle 0 3 -
rd 10000100 - 0000005a
btn 0 ff -
rd 30000000 - 00000000
rd 10000008 - 00000000
wr 30000000 12345678 -
rd 02004000 - ffffffff
rd 02004004 - ffffffff

//--- filelist.f
common/soc_pkg.sv
rtl/reset_sync.sv
rtl/periph_bus.sv
clint/clint.sv
rtl/cycle_timer.sv
rtl/button_port.sv
rtl/soc_periph_top.sv
verification/tb_soc_periph.sv

//--- Bender.yml
package:
  name: soc_periph

sources:
  - common/soc_pkg.sv
  - rtl/reset_sync.sv
  - rtl/periph_bus.sv
  - clint/clint.sv
  - rtl/cycle_timer.sv
  - rtl/button_port.sv
  - rtl/soc_periph_top.sv
  - target: test
    files:
      - verification/tb_soc_periph.sv
